// ==== compile.f ====
+incdir+.
rvPkg.sv
regFile.sv
csrFile.sv
decoder.sv
execute.sv
dataMem.sv
pcUnit.sv
rvCore.sv
tbRvCore.sv

// ==== run.sh ====
#!/bin/sh
# builds the core testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tbRvCore -f compile.f -o tbRvCore \
  && ./obj_dir/tbRvCore > sim.log 2>&1 \
  || { echo "build or run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^=== PASS ===$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tbRvCore.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rvConsts.svh"

module tbRvCore;

  localparam int PERIOD = 20;
  localparam int RST_CYCLES = 8;
  localparam int PROG_LEN = 300;  // ebreak is the last word
  localparam int TOTAL_LEN = PROG_LEN + 4;  // trap handler sits right after
  localparam int HALT_CYCLES = 10;
  // worst case every word is an ecall with its four handler cycles
  localparam int TIMEOUT_CYCLES = 5 * PROG_LEN + 500;
  localparam int MEM_AW = $clog2(`DMEM_WORDS);

  logic clk;
  logic rstN;
  rvPkg::instT instData;
  rvPkg::xlenT instAddr;
  logic retireValid;
  rvPkg::xlenT retirePc;
  logic rdWen;
  rvPkg::regAddrT rdAddr;
  rvPkg::xlenT rdData;
  logic halted;

  rvPkg::instT prog [TOTAL_LEN];
  bit isTarget [TOTAL_LEN];
  int immF3 [5] = '{0, 2, 4, 6, 7};  // addi slti xori ori andi
  int ldF3 [3] = '{3, 2, 6};  // ld lw lwu

  // reference model state
  rvPkg::xlenT regs [32];
  rvPkg::xlenT dmem [`DMEM_WORDS];
  rvPkg::xlenT mPc, mMtvec, mMepc, mMcause, mMstatus;
  bit mHalted;
  int errors;
  int checked;

  rvCore uut (.clk, .rstN, .instAddr, .instData, .retireValid, .retirePc, .rdWen, .rdAddr,
    .rdData, .halted);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  function automatic rvPkg::instT encR(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OP_REG};
  endfunction

  function automatic rvPkg::instT encI(int imm, int rs1, int f3, int rd, logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic rvPkg::instT encS(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], `OP_STORE};
  endfunction

  function automatic rvPkg::instT encB(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], `OP_BRANCH};
  endfunction

  function automatic rvPkg::instT encU(int imm20, int rd, logic [6:0] op);
    return {imm20[19:0], rd[4:0], op};
  endfunction

  function automatic rvPkg::instT encJ(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `OP_JAL};
  endfunction

  function automatic int pickReg();
    return $urandom % 8;
  endfunction

  // x6 stays the load/store base
  function automatic int pickRd();
    int r;
    r = $urandom % 7;
    return (r == 6) ? 7 : r;
  endfunction

  function automatic rvPkg::instT randomRType();
    int f3;
    int f7;
    f3 = $urandom % 8;
    f7 = ((f3 == 0 || f3 == 5) && $urandom % 2 == 1) ? 32 : 0;  // sub, sra
    return encR(f7, pickReg(), pickReg(), f3, pickRd());
  endfunction

  function automatic rvPkg::instT fetchWord(rvPkg::xlenT addr);
    rvPkg::xlenT off;
    off = addr - `RESET_PC;
    if (off < 64'(4 * TOTAL_LEN)) return prog[off[10:2]];
    return 32'h0000_0013;  // nop outside the image
  endfunction

  task automatic genProgram();
    int i, kind, tgt, off, f3, step;
    bit jumpOk;
    rvPkg::csrAddrT csr;
    for (int k = 0; k < TOTAL_LEN; k++) isTarget[k] = 1'b0;
    prog[0] = encU(0, 7, `OP_AUIPC);
    prog[1] = encI(4 * PROG_LEN, 7, 0, 7, `OP_IMM);  // handler address
    prog[2] = encI(int'(`CSR_MTVEC), 7, 1, 0, `OP_SYSTEM);
    prog[3] = encI(256, 0, 0, 6, `OP_IMM);
    i = 4;
    while (i < PROG_LEN - 1) begin
      kind = $urandom % 16;
      tgt = i + 2 + $urandom % 3;
      jumpOk = tgt <= PROG_LEN - 1;
      step = 1;
      prog[i] = randomRType();
      case (kind)
        4, 5: prog[i] = encI(int'($urandom % 4096) - 2048, pickReg(), immF3[$urandom % 5],
                             pickRd(), `OP_IMM);
        6: prog[i] = encU($urandom, pickRd(), ($urandom % 2 == 1) ? `OP_LUI : `OP_AUIPC);
        7, 8: begin
          f3 = ldF3[$urandom % 3];
          off = (f3 == 3) ? 8 * ($urandom % 16) : 4 * ($urandom % 32);
          prog[i] = encI(off, 6, f3, pickRd(), `OP_LOAD);
        end
        9, 10: begin
          f3 = ($urandom % 2 == 1) ? 3 : 2;
          off = (f3 == 3) ? 8 * ($urandom % 16) : 4 * ($urandom % 32);
          prog[i] = encS(off, pickReg(), 6, f3);
        end
        11: if (jumpOk) begin
          prog[i] = encB(4 * (tgt - i), pickReg(), pickReg(), $urandom % 2);
          isTarget[tgt] = 1'b1;
        end
        12: if (jumpOk) begin
          prog[i] = encJ(4 * (tgt - i), pickRd());
          isTarget[tgt] = 1'b1;
        end
        13: if (jumpOk && !isTarget[i + 1]) begin
          prog[i] = encU(0, 7, `OP_AUIPC);  // jalr needs x7 fresh
          prog[i + 1] = encI(4 * (tgt - i), 7, 0, pickRd(), `OP_JALR);
          isTarget[tgt] = 1'b1;
          step = 2;
        end
        14: if ($urandom % 2 == 1) prog[i] = 32'h0000_0073;  // ecall
            else begin
              csr = ($urandom % 2 == 1) ? `CSR_MSTATUS : `CSR_MCAUSE;
              prog[i] = encI(int'(csr), pickReg(), 1, pickRd(), `OP_SYSTEM);
            end
        15: if ($urandom % 4 == 0) prog[i] = encU($urandom, 6, `OP_LUI);
            else prog[i] = encI(8 * int'($urandom % 16) - 64, 6, 0, 6, `OP_IMM);
        default: ;
      endcase
      i += step;
    end
    prog[PROG_LEN - 1] = 32'h0010_0073;  // ebreak
    prog[PROG_LEN] = encI(int'(`CSR_MEPC), 0, 1, 7, `OP_SYSTEM);
    prog[PROG_LEN + 1] = encI(4, 7, 0, 7, `OP_IMM);
    prog[PROG_LEN + 2] = encI(int'(`CSR_MEPC), 7, 1, 0, `OP_SYSTEM);
    prog[PROG_LEN + 3] = 32'h3020_0073;  // mret
  endtask

  task automatic initModel();
    for (int k = 0; k < 32; k++) regs[k] = '0;
    for (int k = 0; k < `DMEM_WORDS; k++) dmem[k] = '0;
    mPc = `RESET_PC;
    mMtvec = '0;
    mMepc = '0;
    mMcause = '0;
    mMstatus = '0;
    mHalted = 1'b0;
  endtask

  // executes one instruction on the model, returns its register write
  task automatic stepModel(input rvPkg::instT inst, output bit wen, output rvPkg::regAddrT rd,
                           output rvPkg::xlenT val);
    rvPkg::xlenT a, b, immI, immS, immB, immU, immJ, addr, nextPc, word;
    logic [31:0] half;
    logic [2:0] f3;
    a = regs[inst[19:15]];
    b = regs[inst[24:20]];
    f3 = inst[14:12];
    rd = inst[11:7];
    immI = {{52{inst[31]}}, inst[31:20]};
    immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    immB = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    immU = {{32{inst[31]}}, inst[31:12], 12'h000};
    immJ = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    addr = a + ((inst[6:0] == `OP_STORE) ? immS : immI);
    nextPc = mPc + 64'd4;
    wen = 1'b0;
    val = '0;
    case (inst[6:0])
      `OP_REG: begin
        wen = 1'b1;
        case (f3)
          3'd0: if (inst[30]) val = a - b; else val = a + b;
          3'd1: val = a << b[5:0];
          3'd2: val = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
          3'd3: val = (a < b) ? 64'd1 : 64'd0;
          3'd4: val = a ^ b;
          3'd5: if (inst[30]) val = $signed(a) >>> b[5:0]; else val = a >> b[5:0];
          3'd6: val = a | b;
          default: val = a & b;
        endcase
      end
      `OP_IMM: begin
        wen = 1'b1;
        case (f3)
          3'd2: val = ($signed(a) < $signed(immI)) ? 64'd1 : 64'd0;
          3'd4: val = a ^ immI;
          3'd6: val = a | immI;
          3'd7: val = a & immI;
          default: val = a + immI;
        endcase
      end
      `OP_LUI: begin
        wen = 1'b1;
        val = immU;
      end
      `OP_AUIPC: begin
        wen = 1'b1;
        val = mPc + immU;
      end
      `OP_LOAD: begin
        wen = 1'b1;
        word = dmem[addr[MEM_AW+2:3]];  // wraps on the memory size
        half = addr[2] ? word[63:32] : word[31:0];
        if (f3 == 3'd3) val = word;
        else if (f3 == 3'd6) val = {32'h0, half};
        else val = {{32{half[31]}}, half};
      end
      `OP_STORE: begin
        if (f3 == 3'd3) dmem[addr[MEM_AW+2:3]] = b;
        else if (addr[2]) dmem[addr[MEM_AW+2:3]][63:32] = b[31:0];
        else dmem[addr[MEM_AW+2:3]][31:0] = b[31:0];
      end
      `OP_BRANCH: if ((f3 == 3'd0) ? (a == b) : (a != b)) nextPc = mPc + immB;
      `OP_JAL: begin
        wen = 1'b1;
        val = mPc + 64'd4;
        nextPc = mPc + immJ;
      end
      `OP_JALR: begin
        wen = 1'b1;
        val = mPc + 64'd4;
        nextPc = (a + immI) & ~64'd1;
      end
      `OP_SYSTEM: begin
        if (f3 == 3'd1) begin
          wen = 1'b1;
          case (inst[31:20])
            `CSR_MTVEC: begin
              val = mMtvec;
              mMtvec = a;
            end
            `CSR_MEPC: begin
              val = mMepc;
              mMepc = a;
            end
            `CSR_MCAUSE: begin
              val = mMcause;
              mMcause = a;
            end
            `CSR_MSTATUS: begin
              val = mMstatus;
              mMstatus = a;
            end
            default: val = '0;
          endcase
        end else if (inst[31:20] == 12'h000) begin
          mMepc = mPc;
          mMcause = `CAUSE_ECALL_M;
          mMstatus[7] = mMstatus[3];  // mpie takes mie
          mMstatus[3] = 1'b0;
          nextPc = mMtvec;
        end else if (inst[31:20] == 12'h001) begin
          mHalted = 1'b1;
          nextPc = mPc;
        end else if (inst[31:20] == 12'h302) begin
          nextPc = mMepc;
        end
      end
      default: ;
    endcase
    if (rd == 5'd0) wen = 1'b0;
    if (wen) regs[rd] = val;
    mPc = nextPc;
  endtask

  task automatic checkRetire();
    bit expWen;
    rvPkg::regAddrT expRd;
    rvPkg::xlenT expVal;
    if (retireValid !== 1'b1 || halted !== 1'b0) begin
      $display("FAIL %0t: core not retiring at pc %h", $time, mPc);
      errors++;
    end
    if (retirePc !== mPc || instAddr !== mPc) begin
      $display("FAIL %0t: pc %h, expected %h", $time, retirePc, mPc);
      errors++;
    end
    stepModel(fetchWord(mPc), expWen, expRd, expVal);
    if (rdWen !== expWen) begin
      $display("FAIL %0t: rdWen %b, expected %b", $time, rdWen, expWen);
      errors++;
    end else if (expWen && (rdAddr !== expRd || rdData !== expVal)) begin
      $display("FAIL %0t: x%0d = %h, expected x%0d = %h", $time, rdAddr, rdData, expRd, expVal);
      errors++;
    end
    checked++;
  endtask

  initial begin
    void'($urandom(32'h5ef6));
    errors = 0;
    checked = 0;
    rstN = 1'b0;
    instData = 32'h0000_0013;
    initModel();
    genProgram();
    repeat (RST_CYCLES) begin
      @(negedge clk);
      if (retireValid !== 1'b0 || rdWen !== 1'b0) begin
        $display("FAIL %0t: retire outputs active during reset", $time);
        errors++;
      end
    end
    rstN = 1'b1;
    while (!mHalted) begin
      instData = fetchWord(instAddr);  // fetch port served every cycle
      #1;
      checkRetire();
      @(negedge clk);
    end
    repeat (HALT_CYCLES) begin
      instData = fetchWord(instAddr);
      #1;
      if (halted !== 1'b1 || retireValid !== 1'b0 || rdWen !== 1'b0 || instAddr !== mPc) begin
        $display("FAIL %0t: core not frozen after ebreak, pc %h", $time, instAddr);
        errors++;
      end
      @(negedge clk);
    end
    $display("checked %0d instructions, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * PERIOD);
    $display("timeout: core did not reach ebreak within %0d cycles", TIMEOUT_CYCLES);
    $display("checked %0d instructions, %0d errors", checked, errors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rvCore.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rvConsts.svh"

module rvCore (
  input  wire            clk,
  input  wire            rstN,
  output rvPkg::xlenT    instAddr,
  input  rvPkg::instT    instData,
  output logic           retireValid,
  output rvPkg::xlenT    retirePc,
  output logic           rdWen,
  output rvPkg::regAddrT rdAddr,
  output rvPkg::xlenT    rdData,
  output logic           halted
);

  rvPkg::xlenT pc, imm, rs1Data, rs2Data, aluRes, wbData, loadData;
  rvPkg::xlenT csrReadData, mtvec, mepc;
  rvPkg::regAddrT rs1Addr, rs2Addr;
  rvPkg::aluOpT aluOp;
  rvPkg::wbSelT wbSel;
  rvPkg::brKindT branchKind;
  rvPkg::csrAddrT csrAddr;
  logic selA, selB, regWen, memRen, memWen, memWord, loadUnsigned;
  logic isJal, isJalr, csrWen, isEcall, isMret, isEbreak, branchTaken;
  logic live;

  assign live        = rstN & ~halted;  // nothing commits in reset or halt
  assign csrAddr     = instData[31:20];
  assign instAddr    = pc;
  assign retirePc    = pc;
  assign retireValid = live;
  assign rdWen       = regWen & live & (rdAddr != '0);
  assign rdData      = wbData;

  decoder uDec (.inst(instData), .rs1Addr, .rs2Addr, .rdAddr, .imm, .aluOp, .selA, .selB,
    .wbSel, .regWen, .memRen, .memWen, .memWord, .loadUnsigned, .branchKind, .isJal,
    .isJalr, .csrWen, .isEcall, .isMret, .isEbreak);

  regFile uRegs (.clk, .rstN, .rs1Addr, .rs2Addr, .rs1Data, .rs2Data, .wen(rdWen),
    .rdAddr, .rdData);

  execute uExe (.pc, .rs1Data, .rs2Data, .imm, .csrReadData, .aluOp, .selA, .selB, .wbSel,
    .loadData, .aluRes, .wbData, .branchTaken, .branchKind);

  dataMem uMem (.clk, .addr(aluRes), .writeData(rs2Data), .memWen(memWen & live),
    .memRen, .memWord, .loadUnsigned, .loadData);

  csrFile uCsr (.clk, .rstN, .csrAddr, .csrWen(csrWen & live), .csrWriteData(aluRes),
    .csrReadData, .trapEnter(isEcall & live), .trapPc(pc), .mtvec, .mepc);

  pcUnit uPc (.clk, .rstN, .halt(isEbreak), .imm, .aluRes, .branchTaken, .isJal, .isJalr,
    .isEcall, .isMret, .mtvec, .mepc, .pc, .halted);

endmodule

`default_nettype wire

// ==== pcUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rvConsts.svh"

module pcUnit (
  input  wire         clk,
  input  wire         rstN,
  input  wire         halt,
  input  rvPkg::xlenT imm,
  input  rvPkg::xlenT aluRes,
  input  wire         branchTaken,
  input  wire         isJal,
  input  wire         isJalr,
  input  wire         isEcall,
  input  wire         isMret,
  input  rvPkg::xlenT mtvec,
  input  rvPkg::xlenT mepc,
  output rvPkg::xlenT pc,
  output logic        halted
);

  rvPkg::xlenT nextPc;

  always_comb begin
    if (isEcall) nextPc = mtvec;
    else if (isMret) nextPc = mepc;
    else if (isJalr) nextPc = {aluRes[63:1], 1'b0};
    else if (isJal || branchTaken) nextPc = pc + imm;
    else nextPc = pc + 64'd4;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc     <= `RESET_PC;
      halted <= 1'b0;
    end else if (!halted) begin
      if (halt) halted <= 1'b1;  // pc stays on the ebreak
      else pc <= nextPc;
    end
  end

endmodule

`default_nettype wire

// ==== dataMem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rvConsts.svh"

module dataMem (
  input  wire         clk,
  input  rvPkg::xlenT addr,
  input  rvPkg::xlenT writeData,
  input  wire         memWen,
  input  wire         memRen,
  input  wire         memWord,
  input  wire         loadUnsigned,
  output rvPkg::xlenT loadData
);

  localparam int AW = $clog2(`DMEM_WORDS);

  rvPkg::xlenT mem [`DMEM_WORDS];
  logic [AW-1:0] idx;
  logic [7:0]    byteMask;
  rvPkg::xlenT   wideData;
  rvPkg::xlenT   rdWord;
  logic [31:0]   half;

  initial begin
    for (int i = 0; i < `DMEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  assign idx      = addr[AW+2:3];  // wraps modulo memory size
  assign byteMask = !memWord ? 8'hff : (addr[2] ? 8'hf0 : 8'h0f);
  assign wideData = memWord ? {writeData[31:0], writeData[31:0]} : writeData;

  always @(posedge clk) begin
    if (memWen) begin
      for (int b = 0; b < 8; b++) begin
        if (byteMask[b]) mem[idx][8*b +: 8] <= wideData[8*b +: 8];
      end
    end
  end

  assign rdWord = mem[idx];
  assign half   = addr[2] ? rdWord[63:32] : rdWord[31:0];

  always_comb begin
    if (!memRen) loadData = '0;
    else if (!memWord) loadData = rdWord;
    else if (loadUnsigned) loadData = {32'b0, half};  // lwu
    else loadData = {{32{half[31]}}, half};  // lw
  end

  // address comes from the alu, alignment is up to the program
  assert property (@(posedge clk) (memRen || memWen) |->
                   (memWord ? addr[1:0] == 2'b0 : addr[2:0] == 3'b0))
    else $error("misaligned data access at %h", addr);

endmodule

`default_nettype wire

// ==== execute.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rvConsts.svh"

module execute (
  input  rvPkg::xlenT   pc,
  input  rvPkg::xlenT   rs1Data,
  input  rvPkg::xlenT   rs2Data,
  input  rvPkg::xlenT   imm,
  input  rvPkg::xlenT   csrReadData,
  input  rvPkg::aluOpT  aluOp,
  input  wire           selA,
  input  wire           selB,
  input  rvPkg::wbSelT  wbSel,
  input  rvPkg::xlenT   loadData,
  output rvPkg::xlenT   aluRes,
  output rvPkg::xlenT   wbData,
  output logic          branchTaken,
  input  rvPkg::brKindT branchKind
);

  rvPkg::xlenT opA;
  rvPkg::xlenT opB;
  logic [5:0]  shamt;

  assign opA   = selA ? pc : rs1Data;
  assign opB   = selB ? imm : rs2Data;
  assign shamt = opB[5:0];  // rv64 shifts use six bits

  always_comb begin
    case (aluOp)
      `ALU_ADD:   aluRes = opA + opB;
      `ALU_SUB:   aluRes = opA - opB;
      `ALU_AND:   aluRes = opA & opB;
      `ALU_OR:    aluRes = opA | opB;
      `ALU_XOR:   aluRes = opA ^ opB;
      `ALU_SLT:   aluRes = {63'b0, $signed(opA) < $signed(opB)};
      `ALU_SLTU:  aluRes = {63'b0, opA < opB};
      `ALU_SLL:   aluRes = opA << shamt;
      `ALU_SRL:   aluRes = opA >> shamt;
      `ALU_SRA:   aluRes = $signed(opA) >>> shamt;
      `ALU_PASSB: aluRes = opB;
      default:    aluRes = '0;
    endcase
  end

  // only beq and bne in this core
  always_comb begin
    case (branchKind)
      `BR_EQ:  branchTaken = rs1Data == rs2Data;
      `BR_NE:  branchTaken = rs1Data != rs2Data;
      default: branchTaken = 1'b0;
    endcase
  end

  always_comb begin
    case (wbSel)
      `WB_MEM: wbData = loadData;
      `WB_PC4: wbData = pc + 64'd4;  // link value
      `WB_CSR: wbData = csrReadData;  // old csr value
      default: wbData = aluRes;
    endcase
  end

endmodule

`default_nettype wire

// ==== decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rvConsts.svh"

module decoder (
  input  rvPkg::instT    inst,
  output rvPkg::regAddrT rs1Addr,
  output rvPkg::regAddrT rs2Addr,
  output rvPkg::regAddrT rdAddr,
  output rvPkg::xlenT    imm,
  output rvPkg::aluOpT   aluOp,
  output logic           selA,
  output logic           selB,
  output rvPkg::wbSelT   wbSel,
  output logic           regWen,
  output logic           memRen,
  output logic           memWen,
  output logic           memWord,
  output logic           loadUnsigned,
  output rvPkg::brKindT  branchKind,
  output logic           isJal,
  output logic           isJalr,
  output logic           csrWen,
  output logic           isEcall,
  output logic           isMret,
  output logic           isEbreak
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rvPkg::xlenT immI, immS, immB, immU, immJ;

  assign opcode  = inst[6:0];
  assign funct3  = inst[14:12];
  assign funct7  = inst[31:25];
  assign rs1Addr = inst[19:15];
  assign rs2Addr = inst[24:20];
  assign rdAddr  = inst[11:7];

  assign immI = {{52{inst[31]}}, inst[31:20]};
  assign immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign immJ = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    imm          = '0;
    aluOp        = `ALU_ADD;
    selA         = 1'b0;  // rs1
    selB         = 1'b0;  // rs2
    wbSel        = `WB_ALU;
    regWen       = 1'b0;
    memRen       = 1'b0;
    memWen       = 1'b0;
    memWord      = 1'b0;
    loadUnsigned = 1'b0;
    branchKind   = `BR_NONE;
    isJal        = 1'b0;
    isJalr       = 1'b0;
    csrWen       = 1'b0;
    isEcall      = 1'b0;
    isMret       = 1'b0;
    isEbreak     = 1'b0;
    case (opcode)
      `OP_REG: begin
        regWen = (funct7 & 7'b1011111) == 7'b0;
        case (funct3)
          3'b000:  aluOp = funct7[5] ? `ALU_SUB : `ALU_ADD;
          3'b001:  aluOp = `ALU_SLL;
          3'b010:  aluOp = `ALU_SLT;
          3'b011:  aluOp = `ALU_SLTU;
          3'b100:  aluOp = `ALU_XOR;
          3'b101:  aluOp = funct7[5] ? `ALU_SRA : `ALU_SRL;
          3'b110:  aluOp = `ALU_OR;
          default: aluOp = `ALU_AND;
        endcase
      end
      `OP_IMM: begin
        imm    = immI;
        selB   = 1'b1;
        regWen = 1'b1;
        case (funct3)
          3'b000:  aluOp = `ALU_ADD;
          3'b010:  aluOp = `ALU_SLT;
          3'b100:  aluOp = `ALU_XOR;
          3'b110:  aluOp = `ALU_OR;
          3'b111:  aluOp = `ALU_AND;
          default: regWen = 1'b0;  // shifts etc not supported
        endcase
      end
      `OP_LOAD: begin
        if (funct3 == 3'b011 || funct3 == 3'b010 || funct3 == 3'b110) begin
          imm          = immI;
          selB         = 1'b1;
          memRen       = 1'b1;
          regWen       = 1'b1;
          wbSel        = `WB_MEM;
          memWord      = funct3[1:0] == 2'b10;
          loadUnsigned = funct3[2];
        end
      end
      `OP_STORE: begin
        if (funct3 == 3'b011 || funct3 == 3'b010) begin
          imm     = immS;
          selB    = 1'b1;
          memWen  = 1'b1;
          memWord = funct3 == 3'b010;
        end
      end
      `OP_BRANCH: begin
        imm = immB;
        if (funct3 == 3'b000) branchKind = `BR_EQ;
        else if (funct3 == 3'b001) branchKind = `BR_NE;
      end
      `OP_JAL: begin
        imm    = immJ;
        isJal  = 1'b1;
        regWen = 1'b1;
        wbSel  = `WB_PC4;
      end
      `OP_JALR: begin
        if (funct3 == 3'b000) begin
          imm    = immI;
          selB   = 1'b1;
          isJalr = 1'b1;
          regWen = 1'b1;
          wbSel  = `WB_PC4;
        end
      end
      `OP_LUI: begin
        imm    = immU;
        selB   = 1'b1;
        aluOp  = `ALU_PASSB;
        regWen = 1'b1;
      end
      `OP_AUIPC: begin
        imm    = immU;
        selA   = 1'b1;
        selB   = 1'b1;
        regWen = 1'b1;
      end
      `OP_SYSTEM: begin
        if (funct3 == 3'b001) begin
          selB   = 1'b1;  // imm stays 0, rs1 passes through
          csrWen = 1'b1;
          regWen = 1'b1;
          wbSel  = `WB_CSR;
        end else if (funct3 == 3'b000 && inst[19:15] == '0 && inst[11:7] == '0) begin
          case (inst[31:20])
            12'h000: isEcall  = 1'b1;
            12'h001: isEbreak = 1'b1;
            12'h302: isMret   = 1'b1;
            default: ;
          endcase
        end
      end
      default: ;  // outside the subset, no-op
    endcase
  end

endmodule

`default_nettype wire

// ==== csrFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rvConsts.svh"

module csrFile (
  input  wire            clk,
  input  wire            rstN,
  input  rvPkg::csrAddrT csrAddr,
  input  wire            csrWen,
  input  rvPkg::xlenT    csrWriteData,
  output rvPkg::xlenT    csrReadData,
  input  wire            trapEnter,
  input  rvPkg::xlenT    trapPc,
  output rvPkg::xlenT    mtvec,
  output rvPkg::xlenT    mepc
);

  rvPkg::xlenT mcause;
  rvPkg::xlenT mstatus;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
      mstatus <= '0;
    end else if (trapEnter) begin
      mepc   <= trapPc;
      mcause <= `CAUSE_ECALL_M;
      mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];
      mstatus[`MSTATUS_MIE]  <= 1'b0;  // interrupts off in the handler
    end else if (csrWen) begin
      case (csrAddr)
        `CSR_MTVEC:   mtvec   <= csrWriteData;
        `CSR_MEPC:    mepc    <= csrWriteData;
        `CSR_MCAUSE:  mcause  <= csrWriteData;
        `CSR_MSTATUS: mstatus <= csrWriteData;
        default:      ;  // unknown csr, write dropped
      endcase
    end
  end

  always_comb begin
    case (csrAddr)
      `CSR_MTVEC:   csrReadData = mtvec;
      `CSR_MEPC:    csrReadData = mepc;
      `CSR_MCAUSE:  csrReadData = mcause;
      `CSR_MSTATUS: csrReadData = mstatus;
      default:      csrReadData = '0;
    endcase
  end

  // decoder never flags csrrw and ecall together
  assert property (@(posedge clk) disable iff (!rstN) !(csrWen && trapEnter))
    else $error("csr write and trap entry in one cycle");

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rvConsts.svh"

module regFile (
  input  wire            clk,
  input  wire            rstN,
  input  rvPkg::regAddrT rs1Addr,
  input  rvPkg::regAddrT rs2Addr,
  output rvPkg::xlenT    rs1Data,
  output rvPkg::xlenT    rs2Data,
  input  wire            wen,
  input  rvPkg::regAddrT rdAddr,
  input  rvPkg::xlenT    rdData
);

  rvPkg::xlenT regs [1:31];  // x0 is not stored

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rdAddr != '0) begin
      regs[rdAddr] <= rdData;
    end
  end

  assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
  assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

  // the core gates x0 writes before they get here
  assert property (@(posedge clk) disable iff (!rstN) wen |-> rdAddr != '0)
    else $error("write enable raised for x0");

endmodule

`default_nettype wire

// ==== rvPkg.sv ====
`default_nettype none

package rvPkg;

  // data and address word
  typedef logic [63:0] xlenT;

  typedef logic [31:0] instT;

  typedef logic [4:0] regAddrT;

  typedef logic [3:0] aluOpT;

  // writeback source: alu, memory, pc+4, csr
  typedef logic [1:0] wbSelT;

  typedef logic [11:0] csrAddrT;

  typedef logic [1:0] brKindT;  // none, beq, bne

endpackage

`default_nettype wire

// ==== rvConsts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RESET_PC      64'h0000_0000_8000_0000
`define DMEM_WORDS    256

`define OP_LUI        7'b0110111
`define OP_AUIPC      7'b0010111
`define OP_JAL        7'b1101111
`define OP_JALR       7'b1100111
`define OP_BRANCH     7'b1100011
`define OP_LOAD       7'b0000011
`define OP_STORE      7'b0100011
`define OP_IMM        7'b0010011
`define OP_REG        7'b0110011
`define OP_SYSTEM     7'b1110011

`define ALU_ADD       4'd0
`define ALU_SUB       4'd1
`define ALU_AND       4'd2
`define ALU_OR        4'd3
`define ALU_XOR       4'd4
`define ALU_SLT       4'd5
`define ALU_SLTU      4'd6
`define ALU_SLL       4'd7
`define ALU_SRL       4'd8
`define ALU_SRA       4'd9
`define ALU_PASSB     4'd10

`define WB_ALU        2'd0
`define WB_MEM        2'd1
`define WB_PC4        2'd2
`define WB_CSR        2'd3

`define BR_NONE       2'd0
`define BR_EQ         2'd1
`define BR_NE         2'd2

`define CSR_MSTATUS   12'h300
`define CSR_MTVEC     12'h305
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342

`define MSTATUS_MIE   3
`define MSTATUS_MPIE  7
`define CAUSE_ECALL_M 64'd11

`endif
